/* verilog/apb_pkg.sv */
// APB slave types and register map of the stream buffer.
// Bus structs travel as single ports through the hierarchy.
`default_nettype none

package apb_pkg;

  // request side, driven by the APB master.
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // response side, driven by the slave.
  typedef struct packed {
    logic        pready;
    logic        pslverr;
    logic [31:0] prdata;
  } apb_rsp_t;

  localparam logic [3:0] ADDR_DATA    = 4'h0; // write pushes one word.
  localparam logic [3:0] ADDR_STATUS  = 4'h4; // read only.
  localparam logic [3:0] ADDR_CONTROL = 4'h8; // bit 0 set flushes.
  localparam logic [3:0] ADDR_DROPS   = 4'hc; // read only.

endpackage

`default_nettype wire

/* verilog/stream_pkg.sv */
// Payload and status types shared by the FIFO core, the APB port and the egress.
`default_nettype none

package stream_pkg;

  // one buffered word with its sequence tag.
  typedef struct packed {
    logic [31:0] data;
    logic [7:0]  seq;
  } entry_t;

  // The layout matches the STATUS register, so empty sits in bit 17,
  // full in bit 16 and the fill level in bits 15:0.
  typedef struct packed {
    logic        empty;
    logic        full;
    logic [15:0] level;
  } status_t;

  localparam int SEQ_W   = 8;
  localparam int LEVEL_W = 16;

endpackage

`default_nettype wire

/* verilog/gray_counter.sv */
// Gray-coded counter that wraps to zero after the code for MAX_COUNT.
// Clear beats set, set beats up; used for the FIFO write and read pointers.
`timescale 1ns/1ps
`default_nettype none

module gray_counter #(
  parameter int MAX_COUNT = 3,
  parameter int WIDTH     = $clog2(MAX_COUNT + 1)
)(
  input  var logic             i_clk,
  input  var logic             i_rst_n,
  input  var logic             i_clear,
  input  var logic             i_set,
  input  var logic [WIDTH-1:0] i_set_value,
  input  var logic             i_up,
  output var logic [WIDTH-1:0] o_gray_count
);

  // gray code of the last count before the wrap.
  localparam logic [WIDTH-1:0] LAST_CODE = WIDTH'(MAX_COUNT ^ (MAX_COUNT >> 1));

  logic [WIDTH-1:0] count;
  logic [WIDTH-1:0] count_next;

  // Next gray code by parity: with even parity bit 0 flips, otherwise
  // the bit just above the lowest set bit flips.
  function automatic logic [WIDTH-1:0] gray_step(input logic [WIDTH-1:0] code);
    logic [WIDTH-1:0] next;
    logic             found;
    next  = code;
    found = 1'b0;
    if (!(^code)) begin
      next[0] = ~code[0];
    end else begin
      for (int i = 0; i < WIDTH - 1; i++) begin
        if (!found && code[i]) begin
          next[i+1] = ~code[i+1];
          found     = 1'b1;
        end
      end
      if (!found) begin
        next[WIDTH-1] = ~code[WIDTH-1]; // top code of a full range rolls to zero.
      end
    end
    return next;
  endfunction

  always_comb begin
    if (count == LAST_CODE) begin
      count_next = '0;
    end else begin
      count_next = gray_step(count);
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      count <= '0;
    end else if (i_clear) begin
      count <= '0;
    end else if (i_set) begin
      count <= i_set_value;
    end else if (i_up) begin
      count <= count_next;
    end
  end

  assign o_gray_count = count;

endmodule

`default_nettype wire

/* verilog/apb_push_port.sv */
// APB slave of the stream buffer. Writes to DATA are tagged and pushed into
// the FIFO core; STATUS, CONTROL and DROPS give software its view and the flush.
`timescale 1ns/1ps
`default_nettype none

module apb_push_port (
  input  var logic                i_clk,
  input  var logic                i_rst_n,
  input  var apb_pkg::apb_req_t   i_apb,
  input  var stream_pkg::status_t i_status,
  output var apb_pkg::apb_rsp_t   o_apb,
  output var logic                o_push,
  output var stream_pkg::entry_t  o_push_entry,
  output var logic                o_clear
);

  logic        access;
  logic        wr_data;
  logic        wr_control;
  logic        push_ok;
  logic        dropped;
  logic        bad_access;
  logic [31:0] rd_value;
  logic [stream_pkg::SEQ_W-1:0] seq;
  logic [15:0] drops;

  // no wait states, so every access phase completes at once.
  assign access     = i_apb.psel & i_apb.penable;
  assign wr_data    = access & i_apb.pwrite & (i_apb.paddr == apb_pkg::ADDR_DATA);
  assign wr_control = access & i_apb.pwrite & (i_apb.paddr == apb_pkg::ADDR_CONTROL);
  assign push_ok    = wr_data & ~i_status.full;
  assign dropped    = wr_data & i_status.full;

  // address decode for reads and for illegal accesses.
  always_comb begin
    rd_value   = '0;
    bad_access = 1'b0;
    case (i_apb.paddr)
      apb_pkg::ADDR_DATA: begin
        bad_access = ~i_apb.pwrite; // the data register is write only.
      end
      apb_pkg::ADDR_STATUS: begin
        rd_value   = 32'(i_status);
        bad_access = i_apb.pwrite;
      end
      apb_pkg::ADDR_CONTROL: begin
        rd_value = '0;
      end
      apb_pkg::ADDR_DROPS: begin
        rd_value   = {16'h0, drops};
        bad_access = i_apb.pwrite;
      end
      default: begin
        bad_access = 1'b1;
      end
    endcase
  end

  assign o_apb.pready  = access;
  assign o_apb.pslverr = access & (bad_access | dropped);
  assign o_apb.prdata  = (access & ~i_apb.pwrite) ? rd_value : '0;

  assign o_push            = wr_data;
  assign o_push_entry.data = i_apb.pwdata;
  assign o_push_entry.seq  = seq;
  assign o_clear           = wr_control & i_apb.pwdata[0];

  // tag counter moves only on accepted pushes.
  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      seq <= '0;
    end else if (o_clear) begin
      seq <= '0;
    end else if (push_ok) begin
      seq <= seq + 1'b1;
    end
  end

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      drops <= '0;
    end else if (o_clear) begin
      drops <= '0;
    end else if (dropped && (drops != 16'hffff)) begin
      drops <= drops + 1'b1; // saturates at the top.
    end
  end

endmodule

`default_nettype wire

/* verilog/gray_fifo_core.sv */
// FIFO storage addressed by gray-coded wrapping pointers that run over twice
// the depth, so full and empty are told apart by the pointer distance.
`timescale 1ns/1ps
`default_nettype none

module gray_fifo_core #(
  parameter int  DEPTH = 5,
  parameter type T     = stream_pkg::entry_t
)(
  input  var logic                i_clk,
  input  var logic                i_rst_n,
  input  var logic                i_push,
  input  var T                    i_push_data,
  input  var logic                i_pop,
  input  var logic                i_clear,
  output var T                    o_head,
  output var stream_pkg::status_t o_status
);

  localparam int              PTR_W  = $clog2(2 * DEPTH);
  localparam int              ADDR_W = $clog2(DEPTH);
  localparam logic [PTR_W:0]  SPAN   = (PTR_W + 1)'(2 * DEPTH);
  localparam logic [PTR_W-1:0] ZERO_CODE = '0;

  T mem [DEPTH];

  logic [PTR_W-1:0]  wr_gray;
  logic [PTR_W-1:0]  rd_gray;
  logic [PTR_W-1:0]  wr_bin;
  logic [PTR_W-1:0]  rd_bin;
  logic [ADDR_W-1:0] wr_addr;
  logic [ADDR_W-1:0] rd_addr;
  logic [PTR_W:0]    level;
  logic              full;
  logic              empty;
  logic              do_push;
  logic              do_pop;

  function automatic logic [PTR_W-1:0] gray_to_bin(input logic [PTR_W-1:0] code);
    logic [PTR_W-1:0] bin;
    bin[PTR_W-1] = code[PTR_W-1];
    for (int i = PTR_W - 2; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ code[i];
    end
    return bin;
  endfunction

  // a pointer below 2*DEPTH maps to its slot by one conditional subtract.
  function automatic logic [ADDR_W-1:0] slot_of(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] slot;
    slot = (ptr >= PTR_W'(DEPTH)) ? ptr - PTR_W'(DEPTH) : ptr;
    return ADDR_W'(slot);
  endfunction

  assign do_push = i_push & ~full & ~i_clear;
  assign do_pop  = i_pop & ~empty & ~i_clear;

  gray_counter #(
    .MAX_COUNT (2 * DEPTH - 1),
    .WIDTH     (PTR_W)
  ) u_wr_ptr (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (i_clear),
    .i_set        (1'b0),
    .i_set_value  (ZERO_CODE),
    .i_up         (do_push),
    .o_gray_count (wr_gray)
  );

  // After a flush the read pointer reloads the write pointer's cleared code.
  gray_counter #(
    .MAX_COUNT (2 * DEPTH - 1),
    .WIDTH     (PTR_W)
  ) u_rd_ptr (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_clear      (1'b0),
    .i_set        (i_clear),
    .i_set_value  (ZERO_CODE),
    .i_up         (do_pop),
    .o_gray_count (rd_gray)
  );

  assign wr_bin  = gray_to_bin(wr_gray);
  assign rd_bin  = gray_to_bin(rd_gray);
  assign wr_addr = slot_of(wr_bin);
  assign rd_addr = slot_of(rd_bin);

  always_comb begin
    if (wr_bin >= rd_bin) begin
      level = {1'b0, wr_bin} - {1'b0, rd_bin};
    end else begin
      level = {1'b0, wr_bin} + SPAN - {1'b0, rd_bin}; // write pointer has wrapped.
    end
  end

  assign full  = (level == (PTR_W + 1)'(DEPTH));
  assign empty = (level == '0);

  always_ff @(posedge i_clk) begin
    if (do_push) begin
      mem[wr_addr] <= i_push_data;
    end
  end

  assign o_head         = mem[rd_addr];
  assign o_status.level = stream_pkg::LEVEL_W'(level);
  assign o_status.full  = full;
  assign o_status.empty = empty;

endmodule

`default_nettype wire

/* verilog/stream_egress.sv */
// One-entry output register between the FIFO core and the valid/ready stream.
// It refills from the core head whenever it is empty or being drained.
`timescale 1ns/1ps
`default_nettype none

module stream_egress #(
  parameter type T = stream_pkg::entry_t
)(
  input  var logic i_clk,
  input  var logic i_rst_n,
  input  var T     i_head,
  input  var logic i_empty,
  input  var logic i_ready,
  output var logic o_pop,
  output var logic o_valid,
  output var T     o_entry
);

  logic valid;
  logic drain;
  T     entry;

  assign drain = valid & i_ready;
  assign o_pop = ~i_empty & (~valid | i_ready);

  always_ff @(posedge i_clk, negedge i_rst_n) begin
    if (!i_rst_n) begin
      valid <= 1'b0;
    end else if (o_pop) begin
      valid <= 1'b1;
    end else if (drain) begin
      valid <= 1'b0;
    end
  end

  // data only moves on a pop, so it holds while stalled.
  always_ff @(posedge i_clk) begin
    if (o_pop) begin
      entry <= i_head;
    end
  end

  assign o_valid = valid;
  assign o_entry = entry;

endmodule

`default_nettype wire

/* verilog/apb_stream_buffer.sv */
// Top of the APB stream buffer: APB push port, gray-pointer FIFO core and
// stream egress register. DEPTH sets the number of FIFO entries.
`timescale 1ns/1ps
`default_nettype none

module apb_stream_buffer #(
  parameter int DEPTH = 5
)(
  input  var logic               i_clk,
  input  var logic               i_rst_n,
  input  var apb_pkg::apb_req_t  i_apb,
  output var apb_pkg::apb_rsp_t  o_apb,
  output var logic               o_valid,
  output var stream_pkg::entry_t o_entry,
  input  var logic               i_ready
);

  logic                push;
  logic                clear;
  logic                pop;
  stream_pkg::entry_t  push_entry;
  stream_pkg::entry_t  head;
  stream_pkg::status_t status;

  apb_push_port u_port (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_apb        (i_apb),
    .i_status     (status),
    .o_apb        (o_apb),
    .o_push       (push),
    .o_push_entry (push_entry),
    .o_clear      (clear)
  );

  gray_fifo_core #(
    .DEPTH (DEPTH),
    .T     (stream_pkg::entry_t)
  ) u_core (
    .i_clk       (i_clk),
    .i_rst_n     (i_rst_n),
    .i_push      (push),
    .i_push_data (push_entry),
    .i_pop       (pop),
    .i_clear     (clear),
    .o_head      (head),
    .o_status    (status)
  );

  stream_egress #(
    .T (stream_pkg::entry_t)
  ) u_egress (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_head  (head),
    .i_empty (status.empty),
    .i_ready (i_ready),
    .o_pop   (pop),
    .o_valid (o_valid),
    .o_entry (o_entry)
  );

endmodule

`default_nettype wire

/* tests/tb_apb_stream_buffer.sv */
// Testbench of the APB stream buffer. A table of APB operations is applied in a loop,
// the expected stream words are kept in a queue and every transfer is compared.
`timescale 1ns/1ps
`default_nettype none

module tb_apb_stream_buffer;

  localparam int DEPTH       = 5;
  localparam int STEP_CYCLES = 40; // cycles allowed for one table step and its drain.

  localparam logic [2:0] OP_WRITE = 3'd0;
  localparam logic [2:0] OP_READ  = 3'd1;
  localparam logic [2:0] OP_FLUSH = 3'd2;
  localparam logic [2:0] OP_READY = 3'd3;
  localparam logic [2:0] OP_DRAIN = 3'd4;

  // the status register holds empty in bit 17, full in bit 16 and the level below.
  localparam logic [31:0] STATUS_EMPTY = 32'h0002_0000;
  localparam logic [31:0] STATUS_FULL  = 32'h0001_0000 | 32'(DEPTH);

  typedef struct packed {
    logic [2:0]  op;
    logic [3:0]  addr;
    logic [31:0] data;
    logic        err;
    logic [31:0] exp_value;
  } step_t;

  logic               clk;
  logic               rst_n;
  apb_pkg::apb_req_t  apb_req;
  apb_pkg::apb_rsp_t  apb_rsp;
  logic               valid;
  stream_pkg::entry_t entry;
  logic               ready;
  logic               ready_random;
  logic [31:0]        lcg_state;
  logic [7:0]         seq_model;
  int                 cycles;
  int                 cycle_limit;
  step_t              steps[$];
  stream_pkg::entry_t expected_q[$];

  apb_stream_buffer #(
    .DEPTH (DEPTH)
  ) dut_i (
    .i_clk   (clk),
    .i_rst_n (rst_n),
    .i_apb   (apb_req),
    .o_apb   (apb_rsp),
    .o_valid (valid),
    .o_entry (entry),
    .i_ready (ready)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic void add_step(input logic [2:0] op, input logic [3:0] addr,
                                   input logic [31:0] data, input logic err,
                                   input logic [31:0] exp_value);
    steps.push_back('{op, addr, data, err, exp_value});
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  // setup phase, then one access phase; the response is sampled inside it.
  task automatic apb_transfer(input logic write, input logic [3:0] addr,
                              input logic [31:0] data, output logic [31:0] rdata,
                              output logic err);
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = data;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    #1;
    check_value("apb pready", 64'(1'b1), 64'(apb_rsp.pready));
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    #1;
    apb_req = '0;
  endtask

  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused_rdata;
    apb_transfer(1'b1, addr, data, unused_rdata, err);
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] rdata, output logic err);
    apb_transfer(1'b0, addr, 32'h0, rdata, err);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // the sink holds ready low or raises it three quarters of the time from the generator.
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (ready_random) begin
        ready = (lcg_next() >> 30) != 32'd0;
      end else begin
        ready = 1'b0;
      end
    end
  end

  // the stream model samples at the falling edge what the next rising edge sees.
  initial begin
    stream_pkg::entry_t want;
    stream_pkg::entry_t held_entry;
    logic               held;
    held       = 1'b0;
    held_entry = '0;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      if (held) begin
        check_value("stalled valid", 64'(1'b1), 64'(valid));
        check_value("stalled entry", 64'(held_entry), 64'(entry));
      end
      held       = valid && !ready;
      held_entry = entry;
      if (valid && ready) begin
        if (expected_q.size() == 0) begin
          $display("stream delivered word %h while none was expected", entry);
          $display("SIMULATION FAILED");
          $fatal(1, "extra stream word");
        end
        want = expected_q.pop_front();
        check_value($sformatf("stream word seq %0d", want.seq), 64'(want), 64'(entry));
      end
    end
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles > cycle_limit) begin
        $display("timeout after %0d cycles, the test did not complete", cycles);
        $display("SIMULATION FAILED");
        $fatal(1, "timeout");
      end
    end
  end

  initial begin
    step_t              step;
    stream_pkg::entry_t ent;
    logic [31:0]        rdata;
    logic               err;
    lcg_state    = 32'h2b10_bcee;
    apb_req      = '0;
    ready        = 1'b0;
    ready_random = 1'b0;
    rst_n        = 1'b0;
    seq_model    = 8'd0;
    add_step(OP_READ, apb_pkg::ADDR_STATUS, 32'h0, 1'b0, STATUS_EMPTY);
    add_step(OP_READ, apb_pkg::ADDR_DROPS, 32'h0, 1'b0, 32'h0);
    add_step(OP_READY, 4'h0, 32'h1, 1'b0, 32'h0);
    for (int i = 0; i < 20; i++) begin
      add_step(OP_WRITE, apb_pkg::ADDR_DATA, lcg_next(), 1'b0, 32'h0);
    end
    add_step(OP_DRAIN, 4'h0, 32'h0, 1'b0, 32'h0);
    add_step(OP_READ, apb_pkg::ADDR_STATUS, 32'h0, 1'b0, STATUS_EMPTY);
    add_step(OP_READY, 4'h0, 32'h0, 1'b0, 32'h0);
    for (int i = 0; i < 9; i++) begin
      add_step(OP_WRITE, apb_pkg::ADDR_DATA, 32'hc0de_0000 + 32'(i), i >= DEPTH + 1, 32'h0);
    end
    add_step(OP_READ, apb_pkg::ADDR_DROPS, 32'h0, 1'b0, 32'd3);
    add_step(OP_READ, apb_pkg::ADDR_STATUS, 32'h0, 1'b0, STATUS_FULL);
    add_step(OP_FLUSH, apb_pkg::ADDR_CONTROL, 32'h1, 1'b0, 32'd1); // egress keeps one word.
    add_step(OP_READ, apb_pkg::ADDR_STATUS, 32'h0, 1'b0, STATUS_EMPTY);
    add_step(OP_READ, apb_pkg::ADDR_DROPS, 32'h0, 1'b0, 32'h0);
    add_step(OP_READY, 4'h0, 32'h1, 1'b0, 32'h0);
    add_step(OP_DRAIN, 4'h0, 32'h0, 1'b0, 32'h0);
    for (int i = 0; i < 3; i++) begin
      add_step(OP_WRITE, apb_pkg::ADDR_DATA, 32'hf00d_0000 + 32'(i), 1'b0, 32'h0);
    end
    add_step(OP_DRAIN, 4'h0, 32'h0, 1'b0, 32'h0);
    add_step(OP_READ, apb_pkg::ADDR_DATA, 32'h0, 1'b1, 32'h0);
    add_step(OP_WRITE, apb_pkg::ADDR_STATUS, 32'h3, 1'b1, 32'h0);
    add_step(OP_WRITE, apb_pkg::ADDR_DROPS, 32'h5, 1'b1, 32'h0);
    add_step(OP_READ, 4'h2, 32'h0, 1'b1, 32'h0);
    add_step(OP_WRITE, 4'h6, 32'h1, 1'b1, 32'h0);
    add_step(OP_READ, apb_pkg::ADDR_STATUS, 32'h0, 1'b0, STATUS_EMPTY);
    add_step(OP_READ, apb_pkg::ADDR_DROPS, 32'h0, 1'b0, 32'h0);
    cycle_limit = 16 + steps.size() * STEP_CYCLES + 64;

    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("valid after reset", 64'(1'b0), 64'(valid));

    for (int idx = 0; idx < steps.size(); idx++) begin
      step = steps[idx];
      case (step.op)
        OP_WRITE: begin
          apb_write(step.addr, step.data, err);
          check_value($sformatf("step %0d write pslverr", idx), 64'(step.err), 64'(err));
          if (step.addr == apb_pkg::ADDR_DATA && !step.err) begin
            ent.data = step.data;
            ent.seq  = seq_model;
            expected_q.push_back(ent);
            seq_model = seq_model + 8'd1;
          end
        end
        OP_READ: begin
          apb_read(step.addr, rdata, err);
          check_value($sformatf("step %0d read pslverr", idx), 64'(step.err), 64'(err));
          if (!step.err) begin
            check_value($sformatf("step %0d read data", idx), 64'(step.exp_value), 64'(rdata));
          end
        end
        OP_FLUSH: begin
          apb_write(step.addr, step.data, err);
          check_value($sformatf("step %0d flush pslverr", idx), 64'(1'b0), 64'(err));
          seq_model = 8'd0;
          while (expected_q.size() > int'(step.exp_value)) begin
            void'(expected_q.pop_back()); // the core loses everything behind the egress.
          end
        end
        OP_READY: ready_random = step.data[0];
        default: begin
          while (expected_q.size() != 0) @(posedge clk);
        end
      endcase
    end

    repeat (20) @(posedge clk); // room for a stray word to show up.
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
verilog/apb_pkg.sv
verilog/stream_pkg.sv
verilog/gray_counter.sv
verilog/apb_push_port.sv
verilog/gray_fifo_core.sv
verilog/stream_egress.sv
verilog/apb_stream_buffer.sv
tests/tb_apb_stream_buffer.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the stream buffer testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir &&
  verilator --binary --timing -Wno-fatal --top-module tb_apb_stream_buffer \
    -f all.f -o tb_sim &&
  ./obj_dir/tb_sim | tee /dev/stderr | grep -q "SIMULATION PASSED" &&
  echo "run.sh: simulation passed" ||
  { echo "run.sh: simulation failed"; exit 1; }
